// ==== design/dcache_defs.svh ====
// cache geometry, fixed at 2 ways x 4 sets x 4 words; changing one width means changing them all
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ----------------------------------------------------------------------
// processor side
// ----------------------------------------------------------------------
`define DCACHE_ADDR_W   30     // word address
`define DCACHE_WORD_W   32

// address split: tag | index | word
`define DCACHE_TAG_W    26
`define DCACHE_IDX_W    2
`define DCACHE_OFS_W    2      // word in line

`define DCACHE_SETS     4

// ----------------------------------------------------------------------
// memory side
// ----------------------------------------------------------------------
`define DCACHE_LINE_W   128    // four words
`define DCACHE_LADDR_W  28     // tag + index

`endif

// ==== design/dcache_pkg.sv ====
// types shared by the data cache blocks; widths come from dcache_defs.svh and are not parameters
`include "dcache_defs.svh"

package dcache_pkg;

	// miss handling states, compare is also the reset state
	typedef enum logic [1:0] {
		st_compare    = 2'd0,
		st_write_back = 2'd1,
		st_allocate   = 2'd2
	} dcache_state_e;

	// processor word address
	typedef struct packed {
		logic [`DCACHE_TAG_W-1:0] tag;
		logic [`DCACHE_IDX_W-1:0] index;
		logic [`DCACHE_OFS_W-1:0] word;
	} proc_addr_s;

	// one line, seen whole by memory and word by word by the processor
	typedef union packed {
		logic [`DCACHE_LINE_W-1:0]                      flat;
		logic [(1 << `DCACHE_OFS_W)-1:0][`DCACHE_WORD_W-1:0] words;
	} cache_line_u;

	typedef struct packed {
		logic                     valid;
		logic                     dirty;
		logic [`DCACHE_TAG_W-1:0] tag;
	} tag_entry_s;

	// store to controller
	typedef struct packed {
		logic hit;             // request present and found in either way
		logic victim_dirty;
		logic victim_valid;
	} look_s;

endpackage

// ==== design/dcache_store.sv ====
// tag/data arrays of a 2-way cache; lookup is combinational, victim way comes from one bit per set
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_store (
	input  logic                       clk,
	input  logic                       proc_reset,
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  dcache_pkg::proc_addr_s     proc_addr,
	input  logic [`DCACHE_WORD_W-1:0]  proc_wdata,
	input  logic [`DCACHE_LINE_W-1:0]  mem_rdata,
	input  logic                       refill_en,
	input  logic                       wb_done,
	output dcache_pkg::look_s          look,
	output logic [`DCACHE_WORD_W-1:0]  proc_rdata,
	output dcache_pkg::cache_line_u    wb_line,
	output logic [`DCACHE_LADDR_W-1:0] wb_laddr
);
	import dcache_pkg::*;

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	tag_entry_s              tags  [2][`DCACHE_SETS];
	cache_line_u             lines [2][`DCACHE_SETS];
	logic [`DCACHE_SETS-1:0] repl;     // way to refill next, one per set

	// ----------------------------------------------------------------------
	// lookup
	// ----------------------------------------------------------------------
	logic [`DCACHE_IDX_W-1:0] idx;
	logic                     req;
	logic [1:0]               way_hit;
	logic                     hit_way;
	logic                     victim;
	tag_entry_s               victim_tag;
	cache_line_u              hit_line;
	logic                     wr_hit;

	assign idx = proc_addr.index;
	assign req = proc_read | proc_write;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = tags[w][idx].valid && (tags[w][idx].tag == proc_addr.tag);
		end
	end

	// both ways never hold the same tag, so way 1 alone decides
	assign hit_way = way_hit[1];

	assign victim     = repl[idx];
	assign victim_tag = tags[victim][idx];

	assign look.hit          = req & (|way_hit);
	assign look.victim_dirty = victim_tag.dirty;
	assign look.victim_valid = victim_tag.valid;

	// read path through the word view
	assign hit_line   = lines[hit_way][idx];
	assign proc_rdata = hit_line.words[proc_addr.word];

	assign wr_hit = proc_write & look.hit;   // only in compare, other states miss

	// write-back source, line address rebuilt from the stored tag
	assign wb_line  = lines[victim][idx];
	assign wb_laddr = {victim_tag.tag, idx};

	// ----------------------------------------------------------------------
	// tag, status and replacement update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				tags[0][s].valid <= 1'b0;
				tags[0][s].dirty <= 1'b0;
				tags[1][s].valid <= 1'b0;
				tags[1][s].dirty <= 1'b0;
			end
			repl <= '0;
		end else if (refill_en) begin
			tags[victim][idx] <= '{valid: 1'b1, dirty: 1'b0, tag: proc_addr.tag};
			repl[idx]         <= ~victim;          // other way goes next
		end else if (wb_done) begin
			tags[victim][idx].dirty <= 1'b0;     // line now matches memory
		end else if (wr_hit) begin
			tags[hit_way][idx].dirty <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// line data
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (refill_en) begin
			lines[victim][idx].flat <= mem_rdata;
		end else if (wr_hit) begin
			lines[hit_way][idx].words[proc_addr.word] <= proc_wdata;
		end
	end

endmodule

// ==== design/dcache_ctrl.sv ====
// miss FSM of the data cache; memory strobes are levels held until mem_ready, no split transactions
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_ctrl (
	input  logic                       clk,
	input  logic                       proc_reset,
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  logic [`DCACHE_LADDR_W-1:0] req_laddr,
	input  logic [`DCACHE_LADDR_W-1:0] wb_laddr,
	input  dcache_pkg::look_s          look,
	input  logic                       mem_ready,
	output logic                       proc_stall,
	output logic                       mem_read,
	output logic                       mem_write,
	output logic [`DCACHE_LADDR_W-1:0] mem_addr,
	output logic                       refill_en,
	output logic                       wb_done
);
	import dcache_pkg::*;

	dcache_state_e state;
	dcache_state_e state_nxt;
	logic          req;
	logic          miss;

	assign req  = proc_read | proc_write;
	assign miss = req & ~look.hit;

	// ----------------------------------------------------------------------
	// state register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= st_compare;
		end else begin
			state <= state_nxt;
		end
	end

	// ----------------------------------------------------------------------
	// next state and outputs
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = req_laddr;
		refill_en  = 1'b0;
		wb_done    = 1'b0;

		case (state)
			st_compare: begin
				proc_stall = miss;                   // hits finish this cycle
				if (miss) begin
					if (look.victim_valid && look.victim_dirty) begin
						state_nxt = st_write_back;
					end else begin
						state_nxt = st_allocate;
					end
				end
			end

			st_write_back: begin
				mem_write = 1'b1;
				mem_addr  = wb_laddr;                // victim line, not the request
				wb_done   = mem_ready;
				if (mem_ready) begin
					state_nxt = st_allocate;
				end
			end

			st_allocate: begin
				mem_read  = 1'b1;
				refill_en = mem_ready;
				if (mem_ready) begin
					state_nxt = st_compare;          // request hits there
				end
			end

			default: begin
				state_nxt = st_compare;
			end
		endcase
	end

endmodule

// ==== design/dcache_top.sv ====
// 2-way write-back data cache, 32-bit word port to 128-bit line port; one request at a time
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_top (
	input  logic                       clk,
	input  logic                       proc_reset,
	// processor side
	input  logic                       proc_read,
	input  logic                       proc_write,
	input  dcache_pkg::proc_addr_s     proc_addr,
	input  logic [`DCACHE_WORD_W-1:0]  proc_wdata,
	output logic [`DCACHE_WORD_W-1:0]  proc_rdata,
	output logic                       proc_stall,
	// memory side
	output logic                       mem_read,
	output logic                       mem_write,
	output logic [`DCACHE_LADDR_W-1:0] mem_addr,
	output logic [`DCACHE_LINE_W-1:0]  mem_wdata,
	input  logic [`DCACHE_LINE_W-1:0]  mem_rdata,
	input  logic                       mem_ready
);
	import dcache_pkg::*;

	look_s                      look;
	cache_line_u                wb_line;
	logic [`DCACHE_LADDR_W-1:0] wb_laddr;
	logic [`DCACHE_LADDR_W-1:0] req_laddr;
	logic                       refill_en;
	logic                       wb_done;

	assign req_laddr = proc_addr[`DCACHE_ADDR_W-1:`DCACHE_OFS_W];  // drop word select
	assign mem_wdata = wb_line.flat;

	dcache_store u_store (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.mem_rdata  (mem_rdata),
		.refill_en  (refill_en),
		.wb_done    (wb_done),
		.look       (look),
		.proc_rdata (proc_rdata),
		.wb_line    (wb_line),
		.wb_laddr   (wb_laddr)
	);

	dcache_ctrl u_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.req_laddr  (req_laddr),
		.wb_laddr   (wb_laddr),
		.look       (look),
		.mem_ready  (mem_ready),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.refill_en  (refill_en),
		.wb_done    (wb_done)
	);

endmodule

// ==== verification/dcache_chk.sv ====
// memory port protocol checks for dcache_top, bound in; failures are counted in fails
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_chk (
	input logic                       clk,
	input logic                       proc_reset,
	input logic                       proc_stall,
	input logic                       mem_read,
	input logic                       mem_write,
	input logic [`DCACHE_LADDR_W-1:0] mem_addr,
	input logic [`DCACHE_LINE_W-1:0]  mem_wdata,
	input logic                       mem_ready
);
	int n_excl  = 0;
	int n_stall = 0;
	int n_hold  = 0;
	int n_reset = 0;
	int fails;

	assign fails = n_excl + n_stall + n_hold + n_reset;

	// ----------------------------------------------------------------------
	// strobes
	// ----------------------------------------------------------------------
	a_one_strobe: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
	else begin
		n_excl++;
		$error("mem_read and mem_write high together");
	end

	a_strobe_stall: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
	else begin
		n_stall++;
		$error("memory strobe without proc_stall");
	end

	// ----------------------------------------------------------------------
	// back-pressure, request held until mem_ready
	// ----------------------------------------------------------------------
	a_read_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
	else begin
		n_hold++;
		$error("mem_read request changed before mem_ready");
	end

	a_write_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr) && $stable(mem_wdata)))
	else begin
		n_hold++;
		$error("mem_write request changed before mem_ready");
	end

	a_reset_quiet: assert property (@(posedge clk)
		$fell(proc_reset) |-> !(mem_read || mem_write))
	else begin
		n_reset++;
		$error("memory strobe right after reset");
	end

endmodule

bind dcache_top dcache_chk u_chk (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_addr   (mem_addr),
	.mem_wdata  (mem_wdata),
	.mem_ready  (mem_ready)
);

// ==== verification/tb_dcache.sv ====
// testbench for dcache_top; the memory model holds 64 lines, so every test address stays below word 256
`timescale 1ns/1ns
`include "dcache_defs.svh"

module tb_dcache;
	import dcache_pkg::*;

	localparam logic [31:0] SEED           = 32'ha64f33dd;
	localparam int          RAND_OPS       = 300;
	// ~330 requests, worst case two 4-cycle transfers plus 4 cycles each, over 4x margin
	localparam int          TIMEOUT_CYCLES = 20000;

	logic                       clk;
	logic                       proc_reset;
	logic                       proc_read;
	logic                       proc_write;
	proc_addr_s                 proc_addr;
	logic [`DCACHE_WORD_W-1:0]  proc_wdata;
	logic [`DCACHE_WORD_W-1:0]  proc_rdata;
	logic                       proc_stall;
	logic                       mem_read;
	logic                       mem_write;
	logic [`DCACHE_LADDR_W-1:0] mem_addr;
	logic [`DCACHE_LINE_W-1:0]  mem_wdata;
	logic [`DCACHE_LINE_W-1:0]  mem_rdata = '0;
	logic                       mem_ready = 1'b0;

	logic [`DCACHE_LINE_W-1:0]  mem_lines [64];     // backing memory, one entry per line
	logic [`DCACHE_WORD_W-1:0]  shadow    [256];    // expected contents, word view
	int                         lat_seed      = SEED;
	int                         data_seed     = SEED;
	int                         wait_left     = 0;
	int                         rd_count      = 0;
	int                         wb_count      = 0;
	int                         cycles        = 0;
	logic [`DCACHE_LADDR_W-1:0] last_rd_laddr = '0;
	logic [`DCACHE_LADDR_W-1:0] last_wb_laddr = '0;

	int check_count    = 0;
	int fail_count     = 0;
	int test_num       = 0;
	int test_chk_base  = 0;
	int test_fail_base = 0;
	int rd_base        = 0;
	int wb_base        = 0;
	int last_stalls    = 0;
	logic [31:0] r;
	logic [31:0] wd;

	dcache_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// every word differs, built from its full word address
	function automatic logic [31:0] fill_word(input logic [7:0] waddr);
		return {8'ha5, waddr, ~waddr, waddr ^ 8'h3c};
	endfunction

	function automatic logic [`DCACHE_ADDR_W-1:0] word_addr(input logic [3:0] tag,
			input logic [1:0] idx, input logic [1:0] wd);
		return {22'd0, tag, idx, wd};
	endfunction

	function automatic logic [`DCACHE_LADDR_W-1:0] line_addr(input logic [3:0] tag,
			input logic [1:0] idx);
		return {22'd0, tag, idx};
	endfunction

	// ----------------------------------------------------------------------
	// memory model
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (proc_reset || !(mem_read || mem_write)) begin
			mem_ready = 1'b0;
			wait_left = 0;
		end else begin
			if (wait_left == 0) begin
				wait_left = 1 + ($random(lat_seed) & 3);   // new transfer, 1 to 4 cycles
			end
			wait_left = wait_left - 1;
			mem_ready = (wait_left == 0);
			mem_rdata = mem_lines[mem_addr[5:0]];
		end
	end

	// transfers complete here, sampled before the DUT's own update
	always @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < 256; i++) begin
				mem_lines[i[7:2]][{i[1:0], 5'b0} +: 32] = fill_word(i[7:0]);
			end
		end else if (mem_ready && mem_write) begin
			mem_lines[mem_addr[5:0]] = mem_wdata;
			wb_count++;
			last_wb_laddr = mem_addr;
		end else if (mem_ready && mem_read) begin
			rd_count++;
			last_rd_laddr = mem_addr;
		end
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a request never completed", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// checking helpers
	// ----------------------------------------------------------------------
	task automatic check(input logic ok, input string msg);
		check_count++;
		assert (ok) else begin
			fail_count++;
			$display("[FAIL] %0t: %s", $time, msg);
		end
	endtask

	task automatic mark_mem();
		rd_base = rd_count;
		wb_base = wb_count;
	endtask

	task automatic check_mem(input int rd_delta, input int wb_delta, input string what);
		check((rd_count - rd_base) == rd_delta && (wb_count - wb_base) == wb_delta,
			$sformatf("%s: %0d line reads, %0d write-backs", what,
				rd_count - rd_base, wb_count - wb_base));
	endtask

	task automatic start_test();
		test_num++;
		test_chk_base  = check_count;
		test_fail_base = fail_count;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %-22s checks %0d errors %0d", test_num, name,
			check_count - test_chk_base, fail_count - test_fail_base);
	endtask

	// one processor request, held until stall drops
	task automatic access(input logic wr, input logic [`DCACHE_ADDR_W-1:0] waddr,
			input logic [31:0] wdata);
		int stalls;
		stalls = 0;
		@(negedge clk);
		proc_read  = ~wr;
		proc_write = wr;
		proc_addr  = waddr;
		proc_wdata = wdata;
		@(posedge clk);
		while (proc_stall) begin
			stalls++;
			@(posedge clk);
		end
		last_stalls = stalls;
		if (wr) begin
			shadow[waddr[7:0]] = wdata;
		end else begin
			check(proc_rdata == shadow[waddr[7:0]], $sformatf("read %h returned %h, expected %h",
				waddr, proc_rdata, shadow[waddr[7:0]]));
		end
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// tests
	// ----------------------------------------------------------------------
	initial begin
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		for (int i = 0; i < 256; i++) begin
			shadow[i[7:0]] = fill_word(i[7:0]);
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;

		start_test();
		mark_mem();
		access(1'b0, word_addr(4'd1, 2'd0, 2'd2), '0);
		check(last_stalls > 0, "read miss did not stall");
		check_mem(1, 0, "read miss");
		check(last_rd_laddr == line_addr(4'd1, 2'd0), "read miss fetched the wrong line");
		mark_mem();
		access(1'b0, word_addr(4'd1, 2'd0, 2'd2), '0);
		check(last_stalls == 0, "repeat read stalled");
		check_mem(0, 0, "repeat read");
		end_test("read miss then hit");

		start_test();
		mark_mem();
		access(1'b1, word_addr(4'd1, 2'd0, 2'd1), 32'h1234_5678);   // line already present
		check(last_stalls == 0, "write hit stalled");
		access(1'b0, word_addr(4'd1, 2'd0, 2'd1), '0);
		check_mem(0, 0, "write hit and read back");
		end_test("write hit");

		// set 1, both ways dirty, then a third tag
		start_test();
		access(1'b0, word_addr(4'd2, 2'd1, 2'd0), '0);
		access(1'b0, word_addr(4'd3, 2'd1, 2'd0), '0);
		access(1'b1, word_addr(4'd2, 2'd1, 2'd3), 32'hd1d1_0002);
		access(1'b1, word_addr(4'd3, 2'd1, 2'd3), 32'hd1d1_0003);
		mark_mem();
		access(1'b0, word_addr(4'd4, 2'd1, 2'd0), '0);
		check_mem(1, 1, "dirty eviction");
		check(last_wb_laddr == line_addr(4'd2, 2'd1), "write-back of the wrong line");
		check(last_rd_laddr == line_addr(4'd4, 2'd1), "refill of the wrong line");
		mark_mem();
		access(1'b0, word_addr(4'd2, 2'd1, 2'd3), '0);     // evicts tag 3, still dirty
		check_mem(1, 1, "second dirty eviction");
		check(last_wb_laddr == line_addr(4'd3, 2'd1), "second write-back of the wrong line");
		mark_mem();
		access(1'b0, word_addr(4'd3, 2'd1, 2'd3), '0);     // victim is clean tag 4
		check_mem(1, 0, "clean eviction");
		end_test("dirty eviction");

		start_test();
		access(1'b0, word_addr(4'd5, 2'd2, 2'd0), '0);
		access(1'b0, word_addr(4'd6, 2'd2, 2'd1), '0);
		mark_mem();
		access(1'b0, word_addr(4'd5, 2'd2, 2'd2), '0);
		check_mem(0, 0, "hit on first-filled line");
		mark_mem();
		access(1'b0, word_addr(4'd7, 2'd2, 2'd3), '0);
		check_mem(1, 0, "third tag");
		mark_mem();
		access(1'b0, word_addr(4'd6, 2'd2, 2'd0), '0);
		check_mem(0, 0, "second-filled line kept");
		mark_mem();
		access(1'b0, word_addr(4'd5, 2'd2, 2'd1), '0);
		check_mem(1, 0, "first-filled line replaced");
		end_test("replacement order");

		// 16 lines, four tags per set
		start_test();
		for (int n = 0; n < RAND_OPS; n++) begin
			r  = $random(data_seed);
			wd = $random(data_seed);
			access(r[0], {24'd0, r[7:4], r[3:2]}, wd);
		end
		end_test("random traffic");

		start_test();
		check_count++;
		if (uut.u_chk.fails != 0) begin
			fail_count++;
			$display("protocol checker reported %0d assertion failures", uut.u_chk.fails);
		end
		end_test("memory protocol");

		$display("summary: %0d tests, %0d checks, %0d errors", test_num, check_count, fail_count);
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_store.sv
design/dcache_ctrl.sv
design/dcache_top.sv
verification/dcache_chk.sv
verification/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_dcache -o sim_dcache &&
./obj_dir/sim_dcache +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "TB PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
